// ==== hw/kalman_cfg.svh ====
`ifndef KALMAN_CFG_SVH
`define KALMAN_CFG_SVH

// ------------------------------------------------
// widths and fixed point
// ------------------------------------------------
`define KF_ADC_BITS  14      // adc sample width.
`define KF_FRAC      13      // gain fraction bits.
`define KF_ONE       8192    // gain of one.
`define KF_GAIN_BITS 14      // quotient width.

// ------------------------------------------------
// latencies
// ------------------------------------------------
`define KF_DIV_LAT   14      // one quotient bit per stage.
`define KF_MUL_LAT   2
`define KF_LATENCY   19      // accepted sample to o_est_valid.

// reset values
`define KF_P_INIT    100000
`define KF_Q_RST     5
`define KF_R_RST     10

`endif

// ==== hw/kalman_num_pkg.sv ====
`include "kalman_cfg.svh"

package kalman_num_pkg;

	// raw adc sample, two's complement.
	typedef logic signed [`KF_ADC_BITS-1:0] adc_t;

	// state estimate.
	typedef logic signed [31:0] est_t;

	// error variance and the noise terms q and r.
	typedef logic [31:0] var_t;

	// gain in 1.13 format, one extra bit so 8192 fits with headroom.
	typedef logic [`KF_GAIN_BITS:0] gain_t;

endpackage

// ==== hw/kalman_reg_pkg.sv ====
package kalman_reg_pkg;

	// host register map.
	typedef enum logic [1:0] {
		REG_Q    = 2'd0,
		REG_R    = 2'd1,
		REG_CTRL = 2'd2
	} reg_addr_e;

	// ------------------------------------------------
	// ctrl register bits
	// ------------------------------------------------
	localparam int CTRL_RESTART = 0;   // self clearing.

endpackage

// ==== hw/kalman_cfg_regs.sv ====
`timescale 1ns/1ps
`include "kalman_cfg.svh"

module kalman_cfg_regs (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_wr,
	input  kalman_reg_pkg::reg_addr_e i_addr,
	input  logic [31:0]               i_wdata,
	output logic [31:0]               o_rdata,
	output kalman_num_pkg::var_t      o_q,
	output kalman_num_pkg::var_t      o_r,
	output logic                      o_restart
);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_q       <= kalman_num_pkg::var_t'(`KF_Q_RST);
			o_r       <= kalman_num_pkg::var_t'(`KF_R_RST);
			o_restart <= 1'b0;
		end else begin
			o_restart <= 1'b0;   // one cycle pulse.
			if (i_wr) begin
				case (i_addr)
					kalman_reg_pkg::REG_Q:    o_q <= i_wdata;
					kalman_reg_pkg::REG_R:    o_r <= i_wdata;
					kalman_reg_pkg::REG_CTRL: o_restart <= i_wdata[kalman_reg_pkg::CTRL_RESTART];
					default:                  ;
				endcase
			end
		end
	end

	// ------------------------------------------------
	// read back, ctrl has no stored bits
	// ------------------------------------------------
	always_comb begin
		case (i_addr)
			kalman_reg_pkg::REG_Q: o_rdata = o_q;
			kalman_reg_pkg::REG_R: o_rdata = o_r;
			default:               o_rdata = '0;
		endcase
	end

endmodule

// ==== hw/gain_divider.sv ====
`timescale 1ns/1ps
`include "kalman_cfg.svh"

module gain_divider (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_stb,
	input  logic [63:0]           i_numer,
	input  kalman_num_pkg::var_t  i_denom,
	output logic                  o_stb,
	output kalman_num_pkg::gain_t o_quot
);

	localparam int STAGES = `KF_DIV_LAT;

	// stage s resolves quotient bit STAGES-1-s, msb first.
	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		localparam int QBIT = STAGES - 1 - s;

		logic                 stb_in;
		logic [63:0]          rem_in;
		kalman_num_pkg::var_t den_in;
		logic [STAGES-1:0]    quo_in;
		logic [63:0]          trial;
		logic                 stb;
		logic [63:0]          rem;
		kalman_num_pkg::var_t den;
		logic [STAGES-1:0]    quo;

		if (s == 0) begin : g_head
			assign stb_in = i_stb;
			assign rem_in = i_numer;
			assign den_in = i_denom;
			assign quo_in = '0;
		end else begin : g_link
			assign stb_in = g_stage[s-1].stb;
			assign rem_in = g_stage[s-1].rem;
			assign den_in = g_stage[s-1].den;
			assign quo_in = g_stage[s-1].quo;
		end

		assign trial = 64'(den_in) << QBIT;   // divisor aligned to this bit.

		always_ff @(posedge i_clk or negedge i_rst_n) begin
			if (!i_rst_n) begin
				stb <= 1'b0;
			end else begin
				stb <= stb_in;
			end
		end

		always_ff @(posedge i_clk) begin
			den <= den_in;
			if (rem_in >= trial) begin
				rem <= rem_in - trial;
				quo <= quo_in | (STAGES'(1) << QBIT);
			end else begin
				rem <= rem_in;   // restore.
				quo <= quo_in;
			end
		end
	end

	assign o_stb  = g_stage[STAGES-1].stb;
	assign o_quot = kalman_num_pkg::gain_t'(g_stage[STAGES-1].quo);

endmodule

// ==== hw/pipe_multiplier.sv ====
`timescale 1ns/1ps

module pipe_multiplier #(
	parameter int STAGES = 2
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_stb,
	input  logic signed [32:0] i_a,
	input  logic signed [32:0] i_b,
	output logic               o_stb,
	output logic signed [63:0] o_prod
);

	logic signed [63:0] prod_q [0:STAGES-1];
	logic [STAGES-1:0]  stb_q;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stb_q <= '0;
		end else begin
			stb_q[0] <= i_stb;
			for (int i = 1; i < STAGES; i++) begin
				stb_q[i] <= stb_q[i-1];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		prod_q[0] <= i_a * i_b;   // operands widen to 64 bits.
		for (int i = 1; i < STAGES; i++) begin
			prod_q[i] <= prod_q[i-1];
		end
	end

	assign o_stb  = stb_q[STAGES-1];
	assign o_prod = prod_q[STAGES-1];

endmodule

// ==== hw/kalman_core.sv ====
`timescale 1ns/1ps
`include "kalman_cfg.svh"

module kalman_core (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_meas_stb,
	input  kalman_num_pkg::adc_t i_meas,
	input  kalman_num_pkg::var_t i_q,
	input  kalman_num_pkg::var_t i_r,
	input  logic                 i_restart,
	output logic                 o_est_valid,
	output kalman_num_pkg::est_t o_est,
	output kalman_num_pkg::var_t o_var,
	output logic                 o_busy,
	output logic                 o_overrun
);

	localparam int DLY = `KF_DIV_LAT;
	localparam int PAD = 33 - $bits(kalman_num_pkg::gain_t);

	typedef enum logic {IDLE, RUN} state_e;

	state_e                state;
	logic [4:0]            cnt;           // cycles since acceptance.
	logic                  accept;
	logic                  fin_go;
	kalman_num_pkg::est_t  x_q;
	kalman_num_pkg::est_t  x_new;
	kalman_num_pkg::var_t  p_q;
	kalman_num_pkg::var_t  p_new;
	kalman_num_pkg::var_t  p_cur;
	logic                  stb0;
	logic                  stb1;
	logic                  stb3;
	kalman_num_pkg::adc_t  meas_c;
	kalman_num_pkg::var_t  pp_c;
	kalman_num_pkg::var_t  r_c;
	kalman_num_pkg::var_t  den_sum;
	logic [63:0]           numer;
	kalman_num_pkg::var_t  denom;
	logic signed [32:0]    err1;
	kalman_num_pkg::var_t  pp1;
	logic signed [32:0]    err_d [0:DLY-1];
	kalman_num_pkg::var_t  pp_d [0:DLY-1];
	logic                  div_stb;
	kalman_num_pkg::gain_t k;
	kalman_num_pkg::gain_t k_r;
	kalman_num_pkg::gain_t omk_r;
	logic signed [32:0]    err_r;
	kalman_num_pkg::var_t  pp_r;
	logic                  fb_stb;
	logic                  pm_stb;
	logic signed [63:0]    fb_prod;
	logic signed [63:0]    pm_prod;

	// ------------------------------------------------
	// sequencing
	// ------------------------------------------------
	// a stale item left in the divider after restart arrives at the wrong count.
	assign fin_go = fb_stb && pm_stb && (state == RUN) && (cnt == 5'(`KF_LATENCY));
	assign accept = i_meas_stb && !i_restart && ((state == IDLE) || fin_go);
	assign o_busy = (state == RUN);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			o_overrun <= 1'b0;
		end else begin
			o_overrun <= i_meas_stb && !accept && !i_restart;
			if (i_restart) begin
				state <= IDLE;
				cnt   <= '0;
			end else if (accept) begin
				state <= RUN;
				cnt   <= 5'd1;
			end else if (fin_go) begin
				state <= IDLE;
			end else if (state == RUN) begin
				cnt <= cnt + 5'd1;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stb0 <= 1'b0;
			stb1 <= 1'b0;
			stb3 <= 1'b0;
		end else begin
			stb0 <= accept;
			stb1 <= stb0 && !i_restart;
			stb3 <= div_stb && !i_restart;
		end
	end

	// ------------------------------------------------
	// predict and set up the division
	// ------------------------------------------------
	assign p_cur   = fin_go ? p_new : p_q;   // bypass when a sample follows back to back.
	assign den_sum = pp_c + r_c;

	always_ff @(posedge i_clk) begin
		if (accept) begin
			meas_c <= i_meas;
			pp_c   <= p_cur + i_q;
			r_c    <= i_r;
		end
		numer <= 64'(pp_c) << `KF_FRAC;
		denom <= (den_sum == '0) ? kalman_num_pkg::var_t'(1) : den_sum;
		err1  <= meas_c - x_q;   // both sides sign extend.
		pp1   <= pp_c;
	end

	// error and pp ride alongside the divider.
	always_ff @(posedge i_clk) begin
		err_d[0] <= err1;
		pp_d[0]  <= pp1;
		for (int i = 1; i < DLY; i++) begin
			err_d[i] <= err_d[i-1];
			pp_d[i]  <= pp_d[i-1];
		end
	end

	gain_divider u_div (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_stb   (stb1),
		.i_numer (numer),
		.i_denom (denom),
		.o_stb   (div_stb),
		.o_quot  (k)
	);

	// ------------------------------------------------
	// update
	// ------------------------------------------------
	always_ff @(posedge i_clk) begin
		k_r   <= k;
		omk_r <= kalman_num_pkg::gain_t'(`KF_ONE) - k;
		err_r <= err_d[DLY-1];
		pp_r  <= pp_d[DLY-1];
	end

	pipe_multiplier #(.STAGES(`KF_MUL_LAT)) u_mul_fb (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_stb   (stb3),
		.i_a     ($signed({{PAD{1'b0}}, k_r})),
		.i_b     (err_r),
		.o_stb   (fb_stb),
		.o_prod  (fb_prod)
	);

	pipe_multiplier #(.STAGES(`KF_MUL_LAT)) u_mul_p (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_stb   (stb3),
		.i_a     ($signed({{PAD{1'b0}}, omk_r})),
		.i_b     ($signed({1'b0, pp_r})),
		.o_stb   (pm_stb),
		.o_prod  (pm_prod)
	);

	assign x_new = x_q + kalman_num_pkg::est_t'(fb_prod >>> `KF_FRAC);
	assign p_new = kalman_num_pkg::var_t'($unsigned(pm_prod) >> `KF_FRAC);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			x_q         <= '0;
			p_q         <= kalman_num_pkg::var_t'(`KF_P_INIT);
			o_est_valid <= 1'b0;
		end else begin
			o_est_valid <= fin_go && !i_restart;
			if (i_restart) begin
				x_q <= '0;
				p_q <= kalman_num_pkg::var_t'(`KF_P_INIT);
			end else if (fin_go) begin
				x_q <= x_new;
				p_q <= p_new;
			end
		end
	end

	assign o_est = x_q;
	assign o_var = p_q;

endmodule

// ==== hw/kalman_top.sv ====
`timescale 1ns/1ps

module kalman_top (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_cfg_wr,
	input  kalman_reg_pkg::reg_addr_e i_cfg_addr,
	input  logic [31:0]               i_cfg_wdata,
	output logic [31:0]               o_cfg_rdata,
	input  logic                      i_meas_stb,
	input  kalman_num_pkg::adc_t      i_meas,
	output logic                      o_est_valid,
	output kalman_num_pkg::est_t      o_est,
	output kalman_num_pkg::var_t      o_var,
	output logic                      o_busy,
	output logic                      o_overrun
);

	kalman_num_pkg::var_t q;
	kalman_num_pkg::var_t r;
	logic                 restart;

	kalman_cfg_regs u_regs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr      (i_cfg_wr),
		.i_addr    (i_cfg_addr),
		.i_wdata   (i_cfg_wdata),
		.o_rdata   (o_cfg_rdata),
		.o_q       (q),
		.o_r       (r),
		.o_restart (restart)
	);

	kalman_core u_core (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_meas_stb  (i_meas_stb),
		.i_meas      (i_meas),
		.i_q         (q),
		.i_r         (r),
		.i_restart   (restart),
		.o_est_valid (o_est_valid),
		.o_est       (o_est),
		.o_var       (o_var),
		.o_busy      (o_busy),
		.o_overrun   (o_overrun)
	);

endmodule

// ==== test/kalman_sva.sv ====
`timescale 1ns/1ps
`include "kalman_cfg.svh"

module kalman_sva (
	input logic                  i_clk,
	input logic                  i_rst_n,
	input logic                  i_accept,
	input logic                  i_restart,
	input logic                  i_est_valid,
	input logic                  i_busy,
	input logic                  i_div_stb,
	input kalman_num_pkg::gain_t i_gain
);

	int fail_count = 0;

	// ------------------------------------------------
	// timing
	// ------------------------------------------------
	a_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_accept ##1 (!i_restart)[*`KF_LATENCY] |=> i_est_valid)
		else begin
			$error("o_est_valid missing after an accepted sample");
			fail_count++;
		end

	a_not_early : assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_accept |=> ##1 (!i_est_valid)[*`KF_LATENCY-1])
		else begin
			$error("o_est_valid came before the pipeline latency");
			fail_count++;
		end

	// range and reset rules.
	a_gain_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_div_stb |-> (i_gain <= `KF_ONE))
		else begin
			$error("gain above unity");
			fail_count++;
		end

	a_idle_after_reset : assert property (@(posedge i_clk)
		$rose(i_rst_n) |-> !i_busy)
		else begin
			$error("o_busy high after reset");
			fail_count++;
		end

endmodule

bind kalman_core kalman_sva u_sva (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_accept    (accept),
	.i_restart   (i_restart),
	.i_est_valid (o_est_valid),
	.i_busy      (o_busy),
	.i_div_stb   (div_stb),
	.i_gain      (k)
);

// ==== test/kalman_tb.sv ====
`timescale 1ns/1ps
`include "kalman_cfg.svh"

module kalman_tb;

	logic                      i_clk = 1'b0;
	logic                      i_rst_n;
	logic                      i_cfg_wr;
	kalman_reg_pkg::reg_addr_e i_cfg_addr;
	logic [31:0]               i_cfg_wdata;
	logic [31:0]               o_cfg_rdata;
	logic                      i_meas_stb;
	kalman_num_pkg::adc_t      i_meas;
	logic                      o_est_valid;
	kalman_num_pkg::est_t      o_est;
	kalman_num_pkg::var_t      o_var;
	logic                      o_busy;
	logic                      o_overrun;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 100;
	int valid_cnt = 0;
	int sample_cnt = 0;
	int start_cycle;
	bit pending = 1'b0;       // a sample is in flight.
	int exp_est;
	int exp_p;

	kalman_top uut (.*);

	always #50 i_clk = ~i_clk;   // 100 ns period.

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout expired after %0d cycles waiting on the DUT", cycles);
			$display("test failed");
			$finish;
		end
	end

	always @(negedge i_clk) begin
		if (o_est_valid === 1'b1)
			valid_cnt++;
	end

	// ------------------------------------------------
	// checks and bus actions
	// ------------------------------------------------
	task automatic check_value(input string what, input logic signed [63:0] got,
		input logic signed [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_sample();
		if (pending) begin
			do
				@(negedge i_clk);
			while (o_est_valid !== 1'b1);
			check_value("latency", cycles - start_cycle, `KF_LATENCY);
			check_value("o_est", o_est, exp_est);
			check_value("o_var", o_var, exp_p);
			check_value("o_busy at o_est_valid", o_busy, 0);
			pending = 1'b0;
		end
	endtask

	task automatic launch_sample(input int meas, input int est, input int p);
		finish_sample();
		@(posedge i_clk);
		i_meas_stb <= 1'b1;
		i_meas     <= kalman_num_pkg::adc_t'(meas);
		@(posedge i_clk);   // accepted on this edge.
		i_meas_stb <= 1'b0;
		@(negedge i_clk);
		check_value("o_busy after accept", o_busy, 1);
		start_cycle = cycles;
		exp_est     = est;
		exp_p       = p;
		pending     = 1'b1;
		sample_cnt++;
	endtask

	task automatic strobe_busy(input int meas);
		if (!pending) begin
			errors++;
			$display("golden file asks for an overrun but no sample is in flight");
		end
		@(posedge i_clk);
		i_meas_stb <= 1'b1;
		i_meas     <= kalman_num_pkg::adc_t'(meas);
		@(posedge i_clk);
		i_meas_stb <= 1'b0;
		@(negedge i_clk);
		check_value("o_overrun", o_overrun, 1);
	endtask

	task automatic write_reg(input int addr, input logic [31:0] data);
		finish_sample();
		@(posedge i_clk);
		i_cfg_wr    <= 1'b1;
		i_cfg_addr  <= kalman_reg_pkg::reg_addr_e'(addr);
		i_cfg_wdata <= data;
		@(posedge i_clk);   // write lands.
		i_cfg_wr <= 1'b0;
		if (addr == kalman_reg_pkg::REG_CTRL && data[kalman_reg_pkg::CTRL_RESTART]) begin
			@(posedge i_clk);   // restart pulse reaches the core.
			@(negedge i_clk);
			check_value("o_est after restart", o_est, 0);
			check_value("o_var after restart", o_var, `KF_P_INIT);
		end
	endtask

	task automatic read_reg(input int addr, input int exp);
		finish_sample();
		@(posedge i_clk);
		i_cfg_addr <= kalman_reg_pkg::reg_addr_e'(addr);
		@(negedge i_clk);
		check_value($sformatf("register %0d", addr), o_cfg_rdata, exp);
	endtask

	// ------------------------------------------------
	// golden file
	// ------------------------------------------------
	function automatic int count_lines();
		int    fd;
		int    lines;
		string line;
		lines = 0;
		fd = $fopen("test/kalman_golden.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0)
				lines++;
			$fclose(fd);
		end
		return lines;
	endfunction

	task automatic run_golden();
		int    fd;
		int    n;
		string line;
		byte   op;
		int    a;
		int    b;
		int    c;
		fd = $fopen("test/kalman_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file test/kalman_golden.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %d %d %d", op, a, b, c);
			if (n != 4) begin
				errors++;
				$display("malformed golden line: %s", line);
				continue;
			end
			case (op)
				"W":     write_reg(a, b);
				"C":     read_reg(a, b);
				"S":     launch_sample(a, b, c);
				"B":     strobe_busy(a);
				default: begin
					errors++;
					$display("unknown opcode in golden line: %s", line);
				end
			endcase
		end
		$fclose(fd);
		finish_sample();
	endtask

	initial begin
		i_rst_n     = 1'b0;
		i_cfg_wr    = 1'b0;
		i_cfg_addr  = kalman_reg_pkg::REG_Q;
		i_cfg_wdata = '0;
		i_meas_stb  = 1'b0;
		i_meas      = '0;
		limit       = 32 * count_lines() + 100;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		check_value("o_est after reset", o_est, 0);
		check_value("o_var after reset", o_var, `KF_P_INIT);
		check_value("o_busy after reset", o_busy, 0);
		check_value("o_overrun after reset", o_overrun, 0);
		run_golden();
		repeat (4) @(negedge i_clk);
		check_value("o_est_valid pulse count", valid_cnt, sample_cnt);   // dropped strobes add none.
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			uut.u_core.u_sva.fail_count);
		if (errors == 0 && uut.u_core.u_sva.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== test/kalman_golden.txt ====
# columns: op a b c, one operation per line
# W addr data 0 | C addr expected 0 | S meas est var | B meas 0 0
# register defaults after reset
C 0 5 0
C 1 10 0
C 2 0 0
# step input with the default q and r
S 1000 999 12
S 1000 999 6
S 2000 1523 5
S 2000 1761 5
# new noise terms, read back, then more samples
W 0 200 0
W 1 50 0
C 0 200 0
C 1 50 0
S 2000 1953 40
S 2000 1991 41
# strobe while busy is dropped
S -500 -72 41
B 3000 0 0
S -500 -427 41
# restart clears the state, ctrl reads back zero
W 2 1 0
C 2 0 0
# adc range limits from the initial state
S 8191 8186 61
S -8192 -5557 41
S -8192 -7740 41

// ==== filelist.f ====
+incdir+hw
hw/kalman_num_pkg.sv
hw/kalman_reg_pkg.sv
hw/kalman_cfg_regs.sv
hw/gain_divider.sv
hw/pipe_multiplier.sv
hw/kalman_core.sv
hw/kalman_top.sv
test/kalman_sva.sv
test/kalman_tb.sv
